/* src/mdu_pkg.sv */
package mdu_pkg;

    // ----------------------------------------------------------------------
    // datapath and tag widths
    // ----------------------------------------------------------------------
    localparam int XLEN = 32;
    typedef logic [XLEN-1:0] word_t;

    // rob tag, also used as the source tag on the cdb
    localparam int ROB_ID_W = 6;
    typedef logic [ROB_ID_W-1:0] rob_id_t;

    // ----------------------------------------------------------------------
    // issue queue geometry
    // ----------------------------------------------------------------------
    localparam int IQ_SIZE  = 8;
    localparam int IQ_PTR_W = $clog2(IQ_SIZE);
    typedef logic [IQ_PTR_W-1:0] iq_ptr_t;

    // instructions per dispatch cycle
    localparam int DISPATCH_W = 2;
    // operands per instruction
    localparam int SRC_COUNT  = 2;
    // common data bus lanes
    localparam int CDB_COUNT  = 2;

    // ----------------------------------------------------------------------
    // mdu operations
    // ----------------------------------------------------------------------
    typedef enum logic [2:0] {
        OP_MUL   = 3'd0,
        OP_MULH  = 3'd1,
        OP_MULHU = 3'd2,
        OP_DIV   = 3'd3,
        OP_DIVU  = 3'd4,
        OP_MOD   = 3'd5,
        OP_MODU  = 3'd6
    } mdu_op_t;

    // edges from accept to result valid
    localparam int MUL_CYCLES = 2;
    localparam int DIV_CYCLES = 34;

endpackage

/* src/iq_entry.sv */
`timescale 1ns/1ps

module iq_entry (
    input  logic                                        clk,
    input  logic                                        reset_i,
    input  logic                                        flush_i,
    input  logic                                        init_i,
    input  logic                                        select_i,

    input  mdu_pkg::mdu_op_t                            op_i,
    input  mdu_pkg::rob_id_t                            rob_id_i,
    input  mdu_pkg::word_t  [mdu_pkg::SRC_COUNT-1:0]    src_data_i,
    input  mdu_pkg::rob_id_t [mdu_pkg::SRC_COUNT-1:0]   src_tag_i,
    input  logic            [mdu_pkg::SRC_COUNT-1:0]    src_valid_i,

    input  logic            [mdu_pkg::CDB_COUNT-1:0]    cdb_valid_i,
    input  mdu_pkg::rob_id_t [mdu_pkg::CDB_COUNT-1:0]   cdb_tag_i,
    input  mdu_pkg::word_t  [mdu_pkg::CDB_COUNT-1:0]    cdb_data_i,

    output logic                                        ready_o,
    output mdu_pkg::mdu_op_t                            op_o,
    output mdu_pkg::rob_id_t                            rob_id_o,
    output mdu_pkg::word_t  [mdu_pkg::SRC_COUNT-1:0]    src_data_o
);

    import mdu_pkg::*;

    logic                           occupied_q;
    mdu_op_t                        op_q;
    rob_id_t                        rob_id_q;
    word_t   [SRC_COUNT-1:0]        data_q;
    rob_id_t [SRC_COUNT-1:0]        tag_q;
    logic    [SRC_COUNT-1:0]        present_q;

    word_t   [SRC_COUNT-1:0]        data_d;
    rob_id_t [SRC_COUNT-1:0]        tag_d;
    logic    [SRC_COUNT-1:0]        present_d;

    // ----------------------------------------------------------------------
    // operand capture
    // ----------------------------------------------------------------------
    // a new instruction goes through the same cdb match as a waiting one,
    // so a broadcast in the dispatch cycle is not missed
    always_comb begin
        for (int s = 0; s < SRC_COUNT; s++) begin
            data_d[s]    = init_i ? src_data_i[s]  : data_q[s];
            tag_d[s]     = init_i ? src_tag_i[s]   : tag_q[s];
            present_d[s] = init_i ? src_valid_i[s] : present_q[s];
            if (!present_d[s]) begin
                for (int c = 0; c < CDB_COUNT; c++) begin
                    if (cdb_valid_i[c] && cdb_tag_i[c] == tag_d[s]) begin
                        data_d[s]    = cdb_data_i[c];
                        present_d[s] = 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            occupied_q <= 1'b0;
            present_q  <= '0;
        end else begin
            if (init_i) begin
                occupied_q <= 1'b1;
            end else if (select_i) begin
                occupied_q <= 1'b0;
            end
            present_q <= present_d;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (init_i) begin
            op_q     <= op_i;
            rob_id_q <= rob_id_i;
        end
        data_q <= data_d;
        tag_q  <= tag_d;
    end

    assign ready_o    = occupied_q && (&present_q);
    assign op_o       = op_q;
    assign rob_id_o   = rob_id_q;
    assign src_data_o = data_q;

    // tail pointer must never land on a live slot
    a_init_free : assert property (@(posedge clk) disable iff (reset_i || flush_i)
        init_i |-> !occupied_q);

endmodule

/* src/mdu.sv */
`timescale 1ns/1ps

module mdu (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                flush_i,

    input  logic                valid_i,
    input  mdu_pkg::mdu_op_t    op_i,
    input  mdu_pkg::rob_id_t    rob_id_i,
    input  mdu_pkg::word_t      src_a_i,
    input  mdu_pkg::word_t      src_b_i,
    output logic                ready_o,

    output logic                valid_o,
    output mdu_pkg::rob_id_t    rob_id_o,
    output mdu_pkg::word_t      data_o,
    input  logic                ready_i
);

    import mdu_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_MUL,
        S_DIV_PREP,
        S_DIV_ITER,
        S_FIX,
        S_DONE
    } state_t;

    typedef logic [$clog2(DIV_CYCLES):0] cnt_t;

    state_t                 state_q;
    cnt_t                   cnt_q;

    mdu_op_t                op_q;
    rob_id_t                rob_q;
    word_t                  a_q;
    word_t                  b_q;
    logic [2*XLEN-1:0]      prod_q;
    word_t                  dvs_q;
    word_t                  rem_q;
    word_t                  quo_q;
    logic                   q_neg_q;
    logic                   r_neg_q;
    logic                   div_zero_q;
    word_t                  res_q;

    logic                   is_div_req;
    logic                   signed_mul;
    logic                   signed_div;
    logic [XLEN:0]          a_ext;
    logic [XLEN:0]          b_ext;
    logic signed [2*XLEN+1:0] mul_full;
    word_t                  a_mag;
    word_t                  b_mag;
    logic [XLEN:0]          rem_shift;
    logic [XLEN+1:0]        rem_diff;
    word_t                  quo_fix;
    word_t                  rem_fix;

    assign is_div_req = op_i inside {OP_DIV, OP_DIVU, OP_MOD, OP_MODU};
    assign signed_mul = op_q inside {OP_MUL, OP_MULH};
    assign signed_div = op_q inside {OP_DIV, OP_MOD};

    // ----------------------------------------------------------------------
    // multiply: 33-bit extension covers both signed and unsigned high words
    // ----------------------------------------------------------------------
    assign a_ext    = {signed_mul & a_q[XLEN-1], a_q};
    assign b_ext    = {signed_mul & b_q[XLEN-1], b_q};
    assign mul_full = $signed(a_ext) * $signed(b_ext);

    // ----------------------------------------------------------------------
    // restoring divider on magnitudes
    // ----------------------------------------------------------------------
    assign a_mag     = (signed_div && a_q[XLEN-1]) ? -a_q : a_q;
    assign b_mag     = (signed_div && b_q[XLEN-1]) ? -b_q : b_q;
    assign rem_shift = {rem_q, quo_q[XLEN-1]};
    assign rem_diff  = {1'b0, rem_shift} - {2'b00, dvs_q};

    // min / -1 needs no special case: the magnitude quotient 2^31 negates
    // back to the dividend and the remainder is already zero
    assign quo_fix = q_neg_q ? -quo_q : quo_q;
    assign rem_fix = r_neg_q ? -rem_q : rem_q;

    // cnt_q counts edges left before the fix stage
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            state_q <= S_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (valid_i) begin
                        if (is_div_req) begin
                            state_q <= S_DIV_PREP;
                            cnt_q   <= cnt_t'(DIV_CYCLES - 1);
                        end else begin
                            state_q <= S_MUL;
                            cnt_q   <= cnt_t'(MUL_CYCLES - 1);
                        end
                    end
                end
                S_MUL, S_DIV_ITER: begin
                    cnt_q <= cnt_q - cnt_t'(1);
                    if (cnt_q == cnt_t'(1)) begin
                        state_q <= S_FIX;
                    end
                end
                S_DIV_PREP: begin
                    cnt_q   <= cnt_q - cnt_t'(1);
                    state_q <= S_DIV_ITER;
                end
                S_FIX: state_q <= S_DONE;
                S_DONE: begin
                    if (ready_i) begin
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state_q)
            S_IDLE: begin
                if (valid_i) begin
                    op_q  <= op_i;
                    rob_q <= rob_id_i;
                    a_q   <= src_a_i;
                    b_q   <= src_b_i;
                end
            end
            S_MUL: prod_q <= mul_full[2*XLEN-1:0];
            S_DIV_PREP: begin
                dvs_q      <= b_mag;
                quo_q      <= a_mag;
                rem_q      <= '0;
                q_neg_q    <= signed_div && (a_q[XLEN-1] ^ b_q[XLEN-1]);
                r_neg_q    <= signed_div && a_q[XLEN-1];
                div_zero_q <= (b_q == '0);
            end
            S_DIV_ITER: begin
                // one quotient bit per edge
                if (!rem_diff[XLEN+1]) begin
                    rem_q <= rem_diff[XLEN-1:0];
                    quo_q <= {quo_q[XLEN-2:0], 1'b1};
                end else begin
                    rem_q <= rem_shift[XLEN-1:0];
                    quo_q <= {quo_q[XLEN-2:0], 1'b0};
                end
            end
            S_FIX: begin
                case (op_q)
                    OP_MUL:            res_q <= prod_q[XLEN-1:0];
                    OP_MULH, OP_MULHU: res_q <= prod_q[2*XLEN-1:XLEN];
                    OP_DIV, OP_DIVU:   res_q <= div_zero_q ? '1 : quo_fix;
                    default:           res_q <= div_zero_q ? a_q : rem_fix;
                endcase
            end
            default: ;
        endcase
    end

    assign ready_o  = (state_q == S_IDLE);
    assign valid_o  = (state_q == S_DONE);
    assign rob_id_o = rob_q;
    assign data_o   = res_q;

    // result holds until the consumer takes it
    a_res_hold : assert property (@(posedge clk) disable iff (reset_i || flush_i)
        valid_o && !ready_i |=> valid_o && $stable(data_o) && $stable(rob_id_o));

    // issue side keeps its request while the unit is busy
    a_req_hold : assert property (@(posedge clk) disable iff (reset_i || flush_i)
        valid_i && !ready_o |=> valid_i && $stable(op_i) && $stable(rob_id_i));

endmodule

/* src/mdu_iq.sv */
`timescale 1ns/1ps

module mdu_iq (
    input  logic                                                        clk,
    input  logic                                                        reset_i,
    input  logic                                                        flush_i,

    input  logic             [mdu_pkg::DISPATCH_W-1:0]                  dispatch_i,
    input  mdu_pkg::mdu_op_t [mdu_pkg::DISPATCH_W-1:0]                  dispatch_op_i,
    input  mdu_pkg::rob_id_t [mdu_pkg::DISPATCH_W-1:0]                  dispatch_rob_id_i,
    input  mdu_pkg::word_t   [mdu_pkg::DISPATCH_W-1:0][mdu_pkg::SRC_COUNT-1:0] src_data_i,
    input  mdu_pkg::rob_id_t [mdu_pkg::DISPATCH_W-1:0][mdu_pkg::SRC_COUNT-1:0] src_tag_i,
    input  logic             [mdu_pkg::DISPATCH_W-1:0][mdu_pkg::SRC_COUNT-1:0] src_valid_i,
    output logic                                                        dispatch_ready_o,

    input  logic             [mdu_pkg::CDB_COUNT-1:0]                   cdb_valid_i,
    input  mdu_pkg::rob_id_t [mdu_pkg::CDB_COUNT-1:0]                   cdb_tag_i,
    input  mdu_pkg::word_t   [mdu_pkg::CDB_COUNT-1:0]                   cdb_data_i,

    output logic                                                        result_valid_o,
    output mdu_pkg::rob_id_t                                            result_rob_id_o,
    output mdu_pkg::word_t                                              result_data_o,
    input  logic                                                        result_ready_i
);

    import mdu_pkg::*;

    typedef logic [IQ_PTR_W:0] count_t;

    iq_ptr_t                    head_q;
    iq_ptr_t                    tail_q;
    iq_ptr_t                    second_slot;
    count_t                     free_cnt_q;
    count_t                     free_cnt_d;

    logic [DISPATCH_W-1:0]      disp_accept;
    logic [1:0]                 disp_count;
    logic                       first_lane;

    logic [IQ_SIZE-1:0]         entry_init;
    logic [IQ_SIZE-1:0]         entry_lane;
    logic [IQ_SIZE-1:0]         entry_select;
    logic [IQ_SIZE-1:0]         entry_ready;
    mdu_op_t                    entry_op   [IQ_SIZE];
    rob_id_t                    entry_rob  [IQ_SIZE];
    word_t [SRC_COUNT-1:0]      entry_data [IQ_SIZE];

    logic                       head_ready;
    logic                       issue_ready;
    logic                       issue;
    logic                       iss_valid_q;
    mdu_op_t                    iss_op_q;
    rob_id_t                    iss_rob_q;
    word_t                      iss_a_q;
    word_t                      iss_b_q;
    logic                       mdu_ready;

    // ----------------------------------------------------------------------
    // dispatch write at the tail
    // ----------------------------------------------------------------------
    assign disp_accept = dispatch_i & {DISPATCH_W{dispatch_ready_o}};
    assign disp_count  = 2'(disp_accept[0]) + 2'(disp_accept[1]);
    // a lone lane 1 still goes to the tail slot
    assign first_lane  = !disp_accept[0];
    assign second_slot = tail_q + iq_ptr_t'(1);

    always_comb begin
        entry_init = '0;
        entry_lane = '0;
        if (disp_count != 2'd0) begin
            entry_init[tail_q] = 1'b1;
            entry_lane[tail_q] = first_lane;
        end
        if (disp_count == 2'd2) begin
            entry_init[second_slot] = 1'b1;
            entry_lane[second_slot] = 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // in-order issue from the head only
    // ----------------------------------------------------------------------
    assign head_ready  = entry_ready[head_q];
    assign issue_ready = !iss_valid_q || mdu_ready;
    assign issue       = head_ready && issue_ready;

    always_comb begin
        entry_select         = '0;
        entry_select[head_q] = issue;
    end

    assign free_cnt_d = free_cnt_q - count_t'(disp_count) + count_t'(issue);

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            head_q           <= '0;
            tail_q           <= '0;
            free_cnt_q       <= count_t'(IQ_SIZE);
            dispatch_ready_o <= 1'b1;
            iss_valid_q      <= 1'b0;
        end else begin
            head_q     <= head_q + iq_ptr_t'(issue);
            tail_q     <= tail_q + iq_ptr_t'(disp_count);
            free_cnt_q <= free_cnt_d;
            // room for a full dual dispatch next cycle
            dispatch_ready_o <= (free_cnt_d >= count_t'(2));
            if (issue_ready) begin
                iss_valid_q <= head_ready;
            end
        end
    end

    // issue register payload
    always_ff @(posedge clk) begin
        if (issue) begin
            iss_op_q  <= entry_op[head_q];
            iss_rob_q <= entry_rob[head_q];
            iss_a_q   <= entry_data[head_q][0];
            iss_b_q   <= entry_data[head_q][1];
        end
    end

    // ----------------------------------------------------------------------
    // queue slots
    // ----------------------------------------------------------------------
    for (genvar i = 0; i < IQ_SIZE; i++) begin : g_entry
        iq_entry i_entry (
            .clk         (clk),
            .reset_i     (reset_i),
            .flush_i     (flush_i),
            .init_i      (entry_init[i]),
            .select_i    (entry_select[i]),
            .op_i        (dispatch_op_i[entry_lane[i]]),
            .rob_id_i    (dispatch_rob_id_i[entry_lane[i]]),
            .src_data_i  (src_data_i[entry_lane[i]]),
            .src_tag_i   (src_tag_i[entry_lane[i]]),
            .src_valid_i (src_valid_i[entry_lane[i]]),
            .cdb_valid_i (cdb_valid_i),
            .cdb_tag_i   (cdb_tag_i),
            .cdb_data_i  (cdb_data_i),
            .ready_o     (entry_ready[i]),
            .op_o        (entry_op[i]),
            .rob_id_o    (entry_rob[i]),
            .src_data_o  (entry_data[i])
        );
    end

    mdu i_mdu (
        .clk      (clk),
        .reset_i  (reset_i),
        .flush_i  (flush_i),
        .valid_i  (iss_valid_q),
        .op_i     (iss_op_q),
        .rob_id_i (iss_rob_q),
        .src_a_i  (iss_a_q),
        .src_b_i  (iss_b_q),
        .ready_o  (mdu_ready),
        .valid_o  (result_valid_o),
        .rob_id_o (result_rob_id_o),
        .data_o   (result_data_o),
        .ready_i  (result_ready_i)
    );

    // occupancy bookkeeping stays within the queue size
    a_free_bound : assert property (@(posedge clk) disable iff (reset_i)
        free_cnt_q <= count_t'(IQ_SIZE));

endmodule

/* verif/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic reset_o
);

    localparam int PERIOD_NS    = 4;
    localparam int RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release just after an edge, like every other driven input
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset_o = 1'b0;
    end

endmodule

/* verif/mdu_iq_tb.sv */
`timescale 1ns/1ps

module mdu_iq_tb;

    import mdu_pkg::*;

    localparam int SEED            = 32'hac76;
    localparam int N_HALF          = 150;
    localparam int N_INSTR         = 2 * N_HALF + 4;
    localparam int WATCHDOG_CYCLES = N_INSTR * 60 + 1000;
    localparam int TAG_COUNT       = 1 << ROB_ID_W;

    logic                                       clk;
    logic                                       reset;
    logic                                       flush;
    logic     [DISPATCH_W-1:0]                  dispatch;
    mdu_op_t  [DISPATCH_W-1:0]                  dispatch_op;
    rob_id_t  [DISPATCH_W-1:0]                  dispatch_rob_id;
    word_t    [DISPATCH_W-1:0][SRC_COUNT-1:0]   src_data;
    rob_id_t  [DISPATCH_W-1:0][SRC_COUNT-1:0]   src_tag;
    logic     [DISPATCH_W-1:0][SRC_COUNT-1:0]   src_valid;
    logic                                       dispatch_ready;
    logic     [CDB_COUNT-1:0]                   cdb_valid;
    rob_id_t  [CDB_COUNT-1:0]                   cdb_tag;
    word_t    [CDB_COUNT-1:0]                   cdb_data;
    logic                                       result_valid;
    rob_id_t                                    result_rob_id;
    word_t                                      result_data;
    logic                                       result_ready;

    // reference model state
    rob_id_t    exp_rob [$];
    word_t      exp_data [$];
    bit         pend_valid [TAG_COUNT];
    word_t      pend_data [TAG_COUNT];
    rob_id_t    next_rob;
    int         dispatched;
    int         dispatch_limit;
    int         results_checked;
    int         edges;
    logic       saw_full;
    logic       hold_pending;
    rob_id_t    held_rob;
    word_t      held_data;

    clk_gen i_clk_gen (
        .clk     (clk),
        .reset_o (reset)
    );

    mdu_iq i_mdu_iq (
        .clk               (clk),
        .reset_i           (reset),
        .flush_i           (flush),
        .dispatch_i        (dispatch),
        .dispatch_op_i     (dispatch_op),
        .dispatch_rob_id_i (dispatch_rob_id),
        .src_data_i        (src_data),
        .src_tag_i         (src_tag),
        .src_valid_i       (src_valid),
        .dispatch_ready_o  (dispatch_ready),
        .cdb_valid_i       (cdb_valid),
        .cdb_tag_i         (cdb_tag),
        .cdb_data_i        (cdb_data),
        .result_valid_o    (result_valid),
        .result_rob_id_o   (result_rob_id),
        .result_data_o     (result_data),
        .result_ready_i    (result_ready)
    );

    // ----------------------------------------------------------------------
    // error reporting and compare tasks
    // ----------------------------------------------------------------------
    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_rob_id(input rob_id_t got, input rob_id_t exp, input string what);
        if (got !== exp) begin
            stop_with_error($sformatf("[FAIL] %0t ns: %s rob id %0d, expected %0d",
                                      $time, what, got, exp));
        end
    endtask

    task automatic check_data(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            stop_with_error($sformatf("[FAIL] %0t ns: %s data %h, expected %h",
                                      $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_with_error($sformatf("[FAIL] %0t ns: %s is %b, expected %b",
                                      $time, what, got, exp));
        end
    endtask

    task automatic check_latency(input int got, input int exp, input string what);
        if (got != exp) begin
            stop_with_error($sformatf("[FAIL] %0t ns: %s took %0d edges, expected %0d",
                                      $time, what, got, exp));
        end
    endtask

    // ----------------------------------------------------------------------
    // arithmetic reference
    // ----------------------------------------------------------------------
    function automatic word_t reference_result(input mdu_op_t op, input word_t a, input word_t b);
        int          sa;
        int          sb;
        logic [63:0] prod;
        logic        ovf;
        word_t       res;
        sa   = int'(a);
        sb   = int'(b);
        // most negative value over minus one
        ovf  = (a == 32'h8000_0000) && (b == '1);
        prod = longint'(sa) * longint'(sb);
        case (op)
            OP_MUL:  res = prod[31:0];
            OP_MULH: res = prod[63:32];
            OP_MULHU: begin
                prod = 64'(a) * 64'(b);
                res  = prod[63:32];
            end
            OP_DIV:  res = (b == '0) ? '1 : (ovf ? a : word_t'(sa / sb));
            OP_DIVU: res = (b == '0) ? '1 : a / b;
            OP_MOD:  res = (b == '0) ? a : (ovf ? '0 : word_t'(sa % sb));
            default: res = (b == '0) ? a : a % b;
        endcase
        return res;
    endfunction

    function automatic word_t rand_operand();
        int pick;
        pick = $urandom % 8;
        case (pick)
            0:       return '0;
            1:       return 32'h8000_0000;
            2:       return '1;
            3:       return 32'h7fff_ffff;
            4:       return word_t'($urandom % 16);
            default: return word_t'($urandom);
        endcase
    endfunction

    function automatic int free_tag();
        int t;
        t = $urandom % TAG_COUNT;
        while (pend_valid[t]) begin
            t = (t + 1) % TAG_COUNT;
        end
        return t;
    endfunction

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------
    task automatic fill_lane(input int k, input mdu_op_t op, input bit all_ready);
        word_t v [SRC_COUNT];
        int    sel;
        int    t;
        sel  = $urandom % 10;
        v[0] = rand_operand();
        v[1] = rand_operand();
        if (sel == 0) begin
            v[0] = 32'h8000_0000;
            v[1] = '1;
        end else if (sel == 1) begin
            v[1] = '0;
        end
        dispatch[k]        = 1'b1;
        dispatch_op[k]     = op;
        dispatch_rob_id[k] = next_rob;
        for (int s = 0; s < SRC_COUNT; s++) begin
            if (all_ready || ($urandom % 2) == 0) begin
                src_valid[k][s] = 1'b1;
                src_data[k][s]  = v[s];
                src_tag[k][s]   = rob_id_t'($urandom);
            end else begin
                // stale data on the bus, the real value comes over the cdb
                t               = free_tag();
                pend_valid[t]   = 1'b1;
                pend_data[t]    = v[s];
                src_valid[k][s] = 1'b0;
                src_tag[k][s]   = rob_id_t'(t);
                src_data[k][s]  = ~v[s];
            end
        end
        exp_rob.push_back(next_rob);
        exp_data.push_back(reference_result(op, v[0], v[1]));
        next_rob   = next_rob + rob_id_t'(1);
        dispatched = dispatched + 1;
        // queue plus issue register plus the unit itself
        if (exp_rob.size() > IQ_SIZE + 2) begin
            stop_with_error("dispatch was accepted with the queue already full");
        end
    endtask

    task automatic drive_cycle(input bit may_dispatch);
        int mode;
        int idx;
        int pend_list [$];
        @(posedge clk);
        #1;
        dispatch     = '0;
        cdb_valid    = '0;
        result_ready = ($urandom % 3) != 0;
        if (!dispatch_ready) begin
            saw_full = 1'b1;
        end
        if (may_dispatch && dispatch_ready && dispatched < dispatch_limit) begin
            mode = $urandom % 4;
            if (mode == 1 || mode == 3) begin
                fill_lane(0, mdu_op_t'($urandom % 7), 1'b0);
            end
            if (mode == 2 || mode == 3) begin
                fill_lane(1, mdu_op_t'($urandom % 7), 1'b0);
            end
        end
        // cdb producer runs after dispatch so a tag can go out in its own dispatch cycle
        for (int t = 0; t < TAG_COUNT; t++) begin
            if (pend_valid[t]) begin
                pend_list.push_back(t);
            end
        end
        for (int c = 0; c < CDB_COUNT; c++) begin
            if (pend_list.size() != 0 && ($urandom % 2) == 0) begin
                idx                     = $urandom % pend_list.size();
                cdb_valid[c]            = 1'b1;
                cdb_tag[c]              = rob_id_t'(pend_list[idx]);
                cdb_data[c]             = pend_data[pend_list[idx]];
                pend_valid[pend_list[idx]] = 1'b0;
                pend_list.delete(idx);
            end
        end
    endtask

    // ----------------------------------------------------------------------
    // result monitor, sampled mid-cycle
    // ----------------------------------------------------------------------
    always @(negedge clk) begin
        if (!reset) begin
            if (hold_pending) begin
                check_flag(result_valid, 1'b1, "result valid under back-pressure");
                check_rob_id(result_rob_id, held_rob, "held result");
                check_data(result_data, held_data, "held result");
            end
            if (result_valid && result_ready) begin
                if (exp_rob.size() == 0) begin
                    stop_with_error("a result arrived with no instruction outstanding");
                end
                check_rob_id(result_rob_id, exp_rob[0], "result");
                check_data(result_data, exp_data[0], "result");
                exp_rob.delete(0);
                exp_data.delete(0);
                results_checked = results_checked + 1;
            end
            hold_pending = result_valid && !result_ready && !flush;
            held_rob     = result_rob_id;
            held_data    = result_data;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_with_error($sformatf("watchdog expired after %0d cycles, results stopped arriving",
                                  WATCHDOG_CYCLES));
    end

    initial begin
        void'($urandom(SEED));
        flush        = 1'b0;
        dispatch     = '0;
        result_ready = 1'b0;
        src_data     = '0;
        src_tag      = '0;
        src_valid    = '0;
        cdb_valid    = '0;
        cdb_tag      = '0;
        cdb_data     = '0;
        for (int k = 0; k < DISPATCH_W; k++) begin
            dispatch_op[k]     = OP_MUL;
            dispatch_rob_id[k] = '0;
        end
        for (int t = 0; t < TAG_COUNT; t++) begin
            pend_valid[t] = 1'b0;
        end
        next_rob        = '0;
        dispatched      = 0;
        results_checked = 0;
        saw_full        = 1'b0;
        hold_pending    = 1'b0;
        @(negedge reset);

        // lone multiply: write edge, issue register edge, mdu accept edge, then MUL_CYCLES
        @(posedge clk);
        #1;
        result_ready = 1'b1;
        fill_lane(0, OP_MUL, 1'b1);
        edges = 0;
        do begin
            @(posedge clk);
            #1;
            dispatch = '0;
            edges    = edges + 1;
        end while (!result_valid);
        check_latency(edges, 3 + MUL_CYCLES, "lone multiply");

        // random traffic, then a flush with work still queued
        dispatch_limit = dispatched + N_HALF;
        while (dispatched < dispatch_limit) begin
            drive_cycle(1'b1);
        end
        repeat ($urandom % 8) drive_cycle(1'b0);
        @(posedge clk);
        #1;
        flush        = 1'b1;
        dispatch     = '0;
        cdb_valid    = '0;
        result_ready = 1'b0;
        exp_rob.delete();
        exp_data.delete();
        for (int t = 0; t < TAG_COUNT; t++) begin
            pend_valid[t] = 1'b0;
        end
        @(posedge clk);
        #1;
        flush = 1'b0;
        check_flag(dispatch_ready, 1'b1, "dispatch ready after flush");
        check_flag(result_valid, 1'b0, "result valid after flush");

        dispatch_limit = dispatched + N_HALF;
        while (dispatched < dispatch_limit) begin
            drive_cycle(1'b1);
        end
        while (exp_rob.size() != 0) begin
            drive_cycle(1'b0);
        end
        // quiet tail catches any extra result
        repeat (40) drive_cycle(1'b0);
        check_flag(saw_full, 1'b1, "dispatch ready drop under back-pressure");

        $display("%0d results checked", results_checked);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* mdu_iq.f */
src/mdu_pkg.sv
src/iq_entry.sv
src/mdu.sv
src/mdu_iq.sv
verif/clk_gen.sv
verif/mdu_iq_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the mdu issue queue testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f mdu_iq.f --top-module mdu_iq_tb -o mdu_iq_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/mdu_iq_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "^Simulation finished: PASS$"; then
    exit 0
fi
exit 1
